/* Bender.yml */
package:
  name: microstepper

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/stepper_pkg.sv
      - rtl/chopper_pkg.sv
      - rtl/step_sequencer.sv
      - rtl/chopper_fsm.sv
      - rtl/chopper_timers.sv
      - rtl/microstepper_control.sv
      - rtl/microstepper_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_microstepper.sv

/* files.f */
+incdir+rtl
rtl/stepper_pkg.sv
rtl/chopper_pkg.sv
rtl/step_sequencer.sv
rtl/chopper_fsm.sv
rtl/chopper_timers.sv
rtl/microstepper_control.sv
rtl/microstepper_top.sv
testbench/tb_microstepper.sv

/* rtl/chopper_fsm.sv */
`timescale 1ns/1ps

module chopper_fsm
  import chopper_pkg::*;
(
  input  logic clk,
  input  logic resetn,
  input  logic offtimer_en,
  input  logic blank_done,
  input  logic off_done,
  output logic load_blank,
  output logic load_off
);

  chop_state_t state;
  chop_state_t state_next;
  logic        load_blank_next;
  logic        load_off_next;

  always_comb begin
    state_next      = state;
    load_blank_next = 1'b0;
    load_off_next   = 1'b0;
    case (state)
      CHOP_IDLE: begin
        // Start first blanking window right away
        state_next      = CHOP_BLANK;
        load_blank_next = 1'b1;
      end
      CHOP_BLANK: begin
        if (blank_done) begin
          state_next = CHOP_ON;
        end
      end
      CHOP_ON: begin
        // Peak current reached, begin fixed off time
        if (offtimer_en) begin
          state_next    = CHOP_OFF;
          load_off_next = 1'b1;
        end
      end
      CHOP_OFF: begin
        if (off_done) begin
          state_next      = CHOP_BLANK;
          load_blank_next = 1'b1;
        end
      end
      default: begin
        state_next = CHOP_IDLE;
      end
    endcase
  end

  // Load strobes are registered with the state
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= CHOP_IDLE;
      load_blank <= 1'b0;
      load_off   <= 1'b0;
    end else begin
      state      <= state_next;
      load_blank <= load_blank_next;
      load_off   <= load_off_next;
    end
  end

  a_loads_exclusive: assert property (
    @(posedge clk) disable iff (!resetn)
    !(load_blank && load_off)
  );

  // Off period may only be started from the on phase
  a_load_off_from_on: assert property (
    @(posedge clk) disable iff (!resetn)
    load_off |-> $past(state == CHOP_ON)
  );

endmodule

/* rtl/chopper_pkg.sv */
`include "stepper_config.svh"

package chopper_pkg;

  // Peak-current chopper states
  typedef enum logic [1:0] {
    CHOP_IDLE,
    CHOP_BLANK,
    CHOP_ON,
    CHOP_OFF
  } chop_state_t;

  // Live counter values of one chopper channel
  typedef struct packed {
    logic [`BLANK_TIMER_W-1:0]  blank;
    logic [`OFF_TIMER_W-1:0]    off;
    logic [`MIN_ON_TIMER_W-1:0] min_on;
  } timer_counts_t;

  // Load values, in clock cycles
  typedef struct packed {
    logic [`BLANK_TIMER_W-1:0]  blank_time;
    logic [`OFF_TIMER_W-1:0]    off_time;
    logic [`MIN_ON_TIMER_W-1:0] min_on_time;
  } chopper_cfg_t;

endpackage

/* rtl/chopper_timers.sv */
`timescale 1ns/1ps

module chopper_timers
  import chopper_pkg::*;
(
  input  logic          clk,
  input  logic          resetn,
  input  logic          load_blank,
  input  logic          load_off,
  input  chopper_cfg_t  cfg,
  output timer_counts_t counts,
  output logic          blank_done,
  output logic          off_done
);

  // Three down-counters, each reloads on its strobe and stops at zero
  always_ff @(posedge clk) begin
    if (!resetn) begin
      counts     <= '0;
      blank_done <= 1'b0;
      off_done   <= 1'b0;
    end else begin
      // Done pulses mark the step from 1 to 0
      blank_done <= !load_blank && (counts.blank == 1);
      off_done   <= !load_off && (counts.off == 1);

      // Minimum on time runs alongside blanking
      if (load_blank) begin
        counts.blank  <= cfg.blank_time;
        counts.min_on <= cfg.min_on_time;
      end else begin
        if (counts.blank != '0) begin
          counts.blank <= counts.blank - 1'b1;
        end
        if (counts.min_on != '0) begin
          counts.min_on <= counts.min_on - 1'b1;
        end
      end

      if (load_off) begin
        counts.off <= cfg.off_time;
      end else if (counts.off != '0) begin
        counts.off <= counts.off - 1'b1;
      end
    end
  end

  // A counter at zero stays there until reloaded
  a_blank_no_wrap: assert property (
    @(posedge clk) disable iff (!resetn)
    ($past(counts.blank) == '0 && !$past(load_blank)) |-> counts.blank == '0
  );

  a_min_on_no_wrap: assert property (
    @(posedge clk) disable iff (!resetn)
    ($past(counts.min_on) == '0 && !$past(load_blank)) |-> counts.min_on == '0
  );

  a_off_no_wrap: assert property (
    @(posedge clk) disable iff (!resetn)
    ($past(counts.off) == '0 && !$past(load_off)) |-> counts.off == '0
  );

endmodule

/* rtl/microstepper_control.sv */
`timescale 1ns/1ps

`include "stepper_config.svh"

module microstepper_control
  import stepper_pkg::*, chopper_pkg::*;
(
  input  logic           clk,
  input  logic           resetn,
  input  drive_pattern_t pattern,
  input  timer_counts_t  counts0,
  input  timer_counts_t  counts1,
  input  drive_cfg_t     drive_cfg,
  input  logic           analog_cmp1,
  input  logic           analog_cmp2,
  output bridge_gates_t  gates_a,
  output bridge_gates_t  gates_b,
  output logic           faultn,
  output logic           offtimer_en0,
  output logic           offtimer_en1
);

  logic          enable;
  logic          fault0;
  logic          fault1;
  decay_mode_t   mode_a;
  decay_mode_t   mode_b;
  bridge_gates_t safe_a;
  bridge_gates_t safe_b;

  // Fast decay while off count is at or above threshold, slow for the rest
  function automatic decay_mode_t decay_of(
    input logic [`OFF_TIMER_W-1:0] off_ct,
    input logic [`OFF_TIMER_W-1:0] threshold
  );
    if (off_ct == '0) begin
      return DECAY_DRIVE;
    end else if (off_ct >= threshold) begin
      return DECAY_FAST;
    end
    return DECAY_SLOW;
  endfunction

  // Decay table, then enable and fault shutdown
  function automatic gate_pair_t half_bridge(
    input decay_mode_t mode,
    input logic        s,
    input logic        en,
    input logic        ok
  );
    gate_pair_t pair;
    case (mode)
      DECAY_FAST: pair = '{high: !s, low: s};
      DECAY_SLOW: pair = '{high: 1'b0, low: 1'b1};
      default:    pair = '{high: s, low: !s};
    endcase
    pair.high = pair.high && en && ok;
    pair.low  = pair.low || !en;
    return pair;
  endfunction

  function automatic bridge_gates_t apply_polarity(
    input bridge_gates_t g,
    input logic          inv_h,
    input logic          inv_l
  );
    bridge_gates_t o;
    o.p1 = '{high: g.p1.high ^ inv_h, low: g.p1.low ^ inv_l};
    o.p2 = '{high: g.p2.high ^ inv_h, low: g.p2.low ^ inv_l};
    return o;
  endfunction

  // Internal enable comes up one cycle after reset release
  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable <= 1'b0;
    end else begin
      enable <= 1'b1;
    end
  end

  // Off period started while minimum on time still running
  assign fault0 = (counts0.off != '0) && (counts0.min_on != '0) && enable;
  assign fault1 = (counts1.off != '0) && (counts1.min_on != '0) && enable;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (fault0 || fault1) begin
      faultn <= 1'b0;
    end
  end

  assign mode_a = decay_of(counts0.off, drive_cfg.fastdecay_threshold);
  assign mode_b = decay_of(counts1.off, drive_cfg.fastdecay_threshold);

  assign safe_a.p1 = half_bridge(mode_a, pattern.s1, enable, faultn);
  assign safe_a.p2 = half_bridge(mode_a, pattern.s2, enable, faultn);
  assign safe_b.p1 = half_bridge(mode_b, pattern.s3, enable, faultn);
  assign safe_b.p2 = half_bridge(mode_b, pattern.s4, enable, faultn);

  assign gates_a = apply_polarity(safe_a, drive_cfg.invert_highside, drive_cfg.invert_lowside);
  assign gates_b = apply_polarity(safe_b, drive_cfg.invert_highside, drive_cfg.invert_lowside);

  // Peak current seen outside blanking and outside an off period
  assign offtimer_en0 = analog_cmp1 && (counts0.blank == '0) && (counts0.off == '0);
  assign offtimer_en1 = analog_cmp2 && (counts1.blank == '0) && (counts1.off == '0);

  // Without a fault every half bridge keeps one gate on, also while enable rises
  a_no_floating_half_bridge: assert property (
    @(posedge clk) disable iff (!resetn)
    faultn |-> ((safe_a.p1.high || safe_a.p1.low) && (safe_a.p2.high || safe_a.p2.low) &&
                (safe_b.p1.high || safe_b.p1.low) && (safe_b.p2.high || safe_b.p2.low))
  );

endmodule

/* rtl/microstepper_top.sv */
`timescale 1ns/1ps

`include "stepper_config.svh"

module microstepper_top
  import stepper_pkg::*, chopper_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     step,
  input  logic                     dir,
  input  logic                     analog_cmp1,
  input  logic                     analog_cmp2,
  input  chopper_cfg_t             chop_cfg,
  input  drive_cfg_t               drive_cfg,
  output bridge_gates_t            gates_a,
  output bridge_gates_t            gates_b,
  output logic                     faultn,
  output logic [`STEP_PHASE_W-1:0] phase_ct
);

  drive_pattern_t pattern;
  timer_counts_t  counts0;
  timer_counts_t  counts1;
  logic           offtimer_en0;
  logic           offtimer_en1;
  logic           load_blank0;
  logic           load_blank1;
  logic           load_off0;
  logic           load_off1;
  logic           blank_done0;
  logic           blank_done1;
  logic           off_done0;
  logic           off_done1;

  step_sequencer i_seq (
    .clk      (clk),
    .resetn   (resetn),
    .step     (step),
    .dir      (dir),
    .phase_ct (phase_ct),
    .pattern  (pattern)
  );

  // Chopper channel for bridge A
  chopper_fsm i_fsm0 (
    .clk         (clk),
    .resetn      (resetn),
    .offtimer_en (offtimer_en0),
    .blank_done  (blank_done0),
    .off_done    (off_done0),
    .load_blank  (load_blank0),
    .load_off    (load_off0)
  );

  chopper_timers i_timers0 (
    .clk        (clk),
    .resetn     (resetn),
    .load_blank (load_blank0),
    .load_off   (load_off0),
    .cfg        (chop_cfg),
    .counts     (counts0),
    .blank_done (blank_done0),
    .off_done   (off_done0)
  );

  // Chopper channel for bridge B
  chopper_fsm i_fsm1 (
    .clk         (clk),
    .resetn      (resetn),
    .offtimer_en (offtimer_en1),
    .blank_done  (blank_done1),
    .off_done    (off_done1),
    .load_blank  (load_blank1),
    .load_off    (load_off1)
  );

  chopper_timers i_timers1 (
    .clk        (clk),
    .resetn     (resetn),
    .load_blank (load_blank1),
    .load_off   (load_off1),
    .cfg        (chop_cfg),
    .counts     (counts1),
    .blank_done (blank_done1),
    .off_done   (off_done1)
  );

  microstepper_control i_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .pattern      (pattern),
    .counts0      (counts0),
    .counts1      (counts1),
    .drive_cfg    (drive_cfg),
    .analog_cmp1  (analog_cmp1),
    .analog_cmp2  (analog_cmp2),
    .gates_a      (gates_a),
    .gates_b      (gates_b),
    .faultn       (faultn),
    .offtimer_en0 (offtimer_en0),
    .offtimer_en1 (offtimer_en1)
  );

endmodule

/* rtl/step_sequencer.sv */
`timescale 1ns/1ps

`include "stepper_config.svh"

module step_sequencer
  import stepper_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     step,
  input  logic                     dir,
  output logic [`STEP_PHASE_W-1:0] phase_ct,
  output drive_pattern_t           pattern
);

  // Two synchroniser stages plus one stage for edge detection
  logic [2:0] step_r;
  logic [1:0] dir_r;
  logic       step_rise;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_r <= '0;
    end else begin
      step_r <= {step_r[1:0], step};
    end
    dir_r <= {dir_r[0], dir};
  end

  assign step_rise = step_r[1] && !step_r[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_ct <= '0;
    end else if (step_rise) begin
      phase_ct <= dir_r[1] ? phase_ct + 1'b1 : phase_ct - 1'b1;
    end
  end

  // Full-step table, two coils always energised
  always_comb begin
    pattern = '0;
    case (phase_ct[1:0])
      2'd0: pattern = '{s1: 1'b1, s2: 1'b0, s3: 1'b1, s4: 1'b0};
      2'd1: pattern = '{s1: 1'b0, s2: 1'b1, s3: 1'b1, s4: 1'b0};
      2'd2: pattern = '{s1: 1'b0, s2: 1'b1, s3: 1'b0, s4: 1'b1};
      default: pattern = '{s1: 1'b1, s2: 1'b0, s3: 1'b0, s4: 1'b1};
    endcase
  end

  // Count moves only right after a detected step edge
  a_phase_only_on_edge: assert property (
    @(posedge clk) disable iff (!resetn)
    ($past(resetn) && !$past(step_rise)) |-> $stable(phase_ct)
  );

endmodule

/* rtl/stepper_config.svh */
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// Phase counter width
// Wraps modulo 256 with 8 bits
`define STEP_PHASE_W 8

// Off-time counter width
`define OFF_TIMER_W 10

// Blanking counter width
`define BLANK_TIMER_W 8

// Minimum on-time counter width
`define MIN_ON_TIMER_W 8

// Default fast-decay threshold in off-timer counts
// Must fit in OFF_TIMER_W bits
`define FASTDECAY_DEFAULT 706

`endif

/* rtl/stepper_pkg.sv */
`include "stepper_config.svh"

package stepper_pkg;

  // One half bridge, high-side and low-side gate
  typedef struct packed {
    logic high;
    logic low;
  } gate_pair_t;

  // Both half bridges of one H-bridge
  typedef struct packed {
    gate_pair_t p1;
    gate_pair_t p2;
  } bridge_gates_t;

  // Wanted high-side states, s1/s2 on bridge A and s3/s4 on bridge B
  typedef struct packed {
    logic s1;
    logic s2;
    logic s3;
    logic s4;
  } drive_pattern_t;

  // Static drive configuration
  typedef struct packed {
    logic [`OFF_TIMER_W-1:0] fastdecay_threshold;
    logic                    invert_highside;
    logic                    invert_lowside;
  } drive_cfg_t;

  typedef enum logic [1:0] {
    DECAY_DRIVE,
    DECAY_FAST,
    DECAY_SLOW
  } decay_mode_t;

endpackage

/* testbench/tb_microstepper.sv */
`timescale 1ns/1ps

`include "stepper_config.svh"

module tb_microstepper
  import stepper_pkg::*, chopper_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_STEPS = 20;
  localparam int FAULT_STEPS = 4;
  localparam int POLARITY_STEPS = 6;
  localparam int OFF_START_LIMIT = 40;
  localparam int DECAY_BLANK = 24;
  localparam int DECAY_OFF = 900;
  localparam int DECAY_MIN_ON = 12;
  localparam int BLANK_BLANK = 30;
  localparam int BLANK_OFF = 720;
  localparam int BLANK_MIN_ON = 10;
  localparam int BLANK_PERIODS = 2;
  localparam int FAULT_BLANK = 16;
  localparam int FAULT_OFF = 800;
  localparam int FAULT_MIN_ON = 60;
  // Summed worst case of all tests plus margin
  localparam int WATCHDOG_CYCLES = 6 * (RESET_CYCLES + 4) + (NUM_STEPS + FAULT_STEPS) * 8
    + POLARITY_STEPS * 6 + DECAY_BLANK + DECAY_OFF + 2 * OFF_START_LIMIT
    + (BLANK_PERIODS + 1) * (BLANK_BLANK + BLANK_OFF + OFF_START_LIMIT)
    + FAULT_BLANK + OFF_START_LIMIT + 500;

  logic                     clk;
  logic                     resetn;
  logic                     step;
  logic                     dir;
  logic                     analog_cmp1;
  logic                     analog_cmp2;
  chopper_cfg_t             chop_cfg;
  drive_cfg_t               drive_cfg;
  bridge_gates_t            gates_a;
  bridge_gates_t            gates_b;
  logic                     faultn;
  logic [`STEP_PHASE_W-1:0] phase_ct;

  logic [`STEP_PHASE_W-1:0] model_phase;
  logic                     model_fault;
  int                       error_count;
  int                       check_count;

  microstepper_top i_dut (
    .clk         (clk),
    .resetn      (resetn),
    .step        (step),
    .dir         (dir),
    .analog_cmp1 (analog_cmp1),
    .analog_cmp2 (analog_cmp2),
    .chop_cfg    (chop_cfg),
    .drive_cfg   (drive_cfg),
    .gates_a     (gates_a),
    .gates_b     (gates_b),
    .faultn      (faultn),
    .phase_ct    (phase_ct)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // Full-step table A+B+, A-B+, A-B-, A+B-
  function automatic drive_pattern_t pattern_of(input logic [1:0] ph);
    drive_pattern_t p;
    p.s1 = (ph == 2'd0) || (ph == 2'd3);
    p.s2 = !p.s1;
    p.s3 = (ph == 2'd0) || (ph == 2'd1);
    p.s4 = !p.s3;
    return p;
  endfunction

  function automatic gate_pair_t model_pair(input decay_mode_t mode, input logic s,
                                            input logic faulted, input logic enabled);
    gate_pair_t p;
    if (mode == DECAY_FAST) begin
      p.high = !s;
      p.low  = s;
    end else if (mode == DECAY_SLOW) begin
      p.high = 1'b0;
      p.low  = 1'b1;
    end else begin
      p.high = s;
      p.low  = !s;
    end
    if (faulted || !enabled) p.high = 1'b0;
    if (!enabled) p.low = 1'b1;
    return p;
  endfunction

  function automatic bridge_gates_t model_bridge(input decay_mode_t mode, input logic s_p1,
                                                 input logic s_p2, input logic faulted,
                                                 input logic enabled, input logic inv_h,
                                                 input logic inv_l);
    bridge_gates_t g;
    g.p1 = model_pair(mode, s_p1, faulted, enabled);
    g.p2 = model_pair(mode, s_p2, faulted, enabled);
    g.p1.high = g.p1.high ^ inv_h;
    g.p2.high = g.p2.high ^ inv_h;
    g.p1.low  = g.p1.low ^ inv_l;
    g.p2.low  = g.p2.low ^ inv_l;
    return g;
  endfunction

  // Expected gates of bridge A or B from the modelled phase and fault state
  function automatic bridge_gates_t expect_bridge(input bit on_b, input decay_mode_t mode,
                                                  input logic enabled);
    drive_pattern_t p;
    p = pattern_of(model_phase[1:0]);
    return model_bridge(mode, on_b ? p.s3 : p.s1, on_b ? p.s4 : p.s2, model_fault, enabled,
                        drive_cfg.invert_highside, drive_cfg.invert_lowside);
  endfunction

  function automatic bit bridge_shows(input bit on_b, input decay_mode_t mode);
    return (on_b ? gates_b : gates_a) === expect_bridge(on_b, mode, 1'b1);
  endfunction

  task automatic compare_gates(input string test, input string what,
                               input bridge_gates_t exp, input bridge_gates_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Mismatch in %s, %s: expected %b, actual %b", test, what, exp, act);
    end
  endtask

  task automatic compare_phase(input string test, input logic [`STEP_PHASE_W-1:0] exp,
                               input logic [`STEP_PHASE_W-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Mismatch in %s, phase_ct: expected %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic compare_fault(input string test, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Mismatch in %s, faultn: expected %b, actual %b", test, exp, act);
    end
  endtask

  task automatic compare_count(input string test, input string what, input int exp,
                               input int act);
    check_count++;
    if (act != exp) begin
      error_count++;
      $display("Mismatch in %s, %s: expected %0d, actual %0d", test, what, exp, act);
    end
  endtask

  task automatic report_failure(input string test, input string msg);
    error_count++;
    $display("Error in %s: %s", test, msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Holds reset for four cycles and checks the safe state while it is low
  // Returns once the internal enable is up
  task automatic apply_reset(input string test);
    next_cycle();
    resetn = 1'b0;
    step = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    model_phase = '0;
    model_fault = 1'b0;
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      compare_fault(test, 1'b1, faultn);
      compare_phase(test, '0, phase_ct);
      compare_gates(test, "gates_a in reset", expect_bridge(1'b0, DECAY_DRIVE, 1'b0), gates_a);
      compare_gates(test, "gates_b in reset", expect_bridge(1'b1, DECAY_DRIVE, 1'b0), gates_b);
    end
    next_cycle();
    resetn = 1'b1;
    next_cycle();
  endtask

  task automatic send_step(input logic d, input int high_cycles);
    next_cycle();
    dir = d;
    step = 1'b1;
    repeat (high_cycles) next_cycle();
    step = 1'b0;
    repeat (4) next_cycle();
    model_phase = d ? model_phase + 1'b1 : model_phase - 1'b1;
  endtask

  // Called at a falling edge; counts drive cycles until the bridge leaves drive
  task automatic wait_for_off(input string test, input bit on_b, input int limit,
                              output int drive_n, output bit found);
    drive_n = 0;
    found = 1'b0;
    while (!found && drive_n < limit) begin
      if (!bridge_shows(on_b, DECAY_DRIVE)) begin
        found = 1'b1;
      end else begin
        drive_n++;
        @(negedge clk);
      end
    end
    if (!found) begin
      report_failure(test, $sformatf("no off period started on bridge %s within %0d cycles",
                                     on_b ? "B" : "A", limit));
    end
  endtask

  // Other bridge must stay in drive meanwhile
  task automatic count_mode(input string test, input bit on_b, input decay_mode_t mode,
                            input int limit, output int n);
    n = 0;
    while (n < limit && bridge_shows(on_b, mode)) begin
      n++;
      compare_gates(test, "other bridge", expect_bridge(!on_b, DECAY_DRIVE, 1'b1),
                    on_b ? gates_a : gates_b);
      @(negedge clk);
    end
  endtask

  task automatic test_reset();
    string test;
    test = "test_reset";
    apply_reset(test);
    repeat (2) next_cycle();
    @(negedge clk);
    compare_fault(test, 1'b1, faultn);
    compare_phase(test, '0, phase_ct);
    compare_gates(test, "gates_a", expect_bridge(1'b0, DECAY_DRIVE, 1'b1), gates_a);
    compare_gates(test, "gates_b", expect_bridge(1'b1, DECAY_DRIVE, 1'b1), gates_b);
  endtask

  task automatic test_stepping();
    string test;
    test = "test_stepping";
    apply_reset(test);
    for (int i = 0; i < NUM_STEPS; i++) begin
      send_step($urandom % 2, 1 + $urandom % 3);
      @(negedge clk);
      compare_phase(test, model_phase, phase_ct);
      compare_gates(test, "gates_a", expect_bridge(1'b0, DECAY_DRIVE, 1'b1), gates_a);
      compare_gates(test, "gates_b", expect_bridge(1'b1, DECAY_DRIVE, 1'b1), gates_b);
    end
  endtask

  task automatic test_decay();
    string test;
    int drive_n;
    int fast_n;
    int slow_n;
    bit found;
    test = "test_decay";
    next_cycle();
    chop_cfg = '{blank_time: DECAY_BLANK, off_time: DECAY_OFF, min_on_time: DECAY_MIN_ON};
    apply_reset(test);
    repeat (DECAY_BLANK + 8) next_cycle();
    analog_cmp1 = 1'b1;
    @(negedge clk);
    wait_for_off(test, 1'b0, OFF_START_LIMIT, drive_n, found);
    if (found) begin
      // First fast cycle already seen and the comparator is released after it
      next_cycle();
      analog_cmp1 = 1'b0;
      @(negedge clk);
      count_mode(test, 1'b0, DECAY_FAST, DECAY_OFF + 4, fast_n);
      count_mode(test, 1'b0, DECAY_SLOW, DECAY_OFF + 4, slow_n);
      compare_count(test, "fast-decay cycles", DECAY_OFF - `FASTDECAY_DEFAULT + 1, fast_n + 1);
      compare_count(test, "slow-decay cycles", `FASTDECAY_DEFAULT - 1, slow_n);
      compare_gates(test, "gates_a after off", expect_bridge(1'b0, DECAY_DRIVE, 1'b1), gates_a);
      compare_gates(test, "gates_b", expect_bridge(1'b1, DECAY_DRIVE, 1'b1), gates_b);
    end
    compare_fault(test, 1'b1, faultn);
  endtask

  task automatic test_blanking();
    string test;
    int drive_n;
    int fast_n;
    int slow_n;
    int periods;
    bit found;
    test = "test_blanking";
    next_cycle();
    chop_cfg = '{blank_time: BLANK_BLANK, off_time: BLANK_OFF, min_on_time: BLANK_MIN_ON};
    apply_reset(test);
    analog_cmp2 = 1'b1;
    @(negedge clk);
    periods = 0;
    found = 1'b1;
    while (found && periods < BLANK_PERIODS) begin
      wait_for_off(test, 1'b1, BLANK_BLANK + OFF_START_LIMIT, drive_n, found);
      if (found) begin
        if (drive_n < BLANK_BLANK) begin
          report_failure(test, $sformatf("off period %0d began after only %0d drive cycles",
                                         periods, drive_n));
        end
        count_mode(test, 1'b1, DECAY_FAST, BLANK_OFF + 4, fast_n);
        count_mode(test, 1'b1, DECAY_SLOW, BLANK_OFF + 4, slow_n);
        compare_count(test, "off period cycles", BLANK_OFF, fast_n + slow_n);
        compare_fault(test, 1'b1, faultn);
      end
      periods++;
    end
    next_cycle();
    analog_cmp2 = 1'b0;
  endtask

  task automatic test_fault();
    string test;
    int drive_n;
    bit found;
    test = "test_fault";
    next_cycle();
    chop_cfg = '{blank_time: FAULT_BLANK, off_time: FAULT_OFF, min_on_time: FAULT_MIN_ON};
    apply_reset(test);
    analog_cmp1 = 1'b1;
    @(negedge clk);
    wait_for_off(test, 1'b0, FAULT_BLANK + OFF_START_LIMIT, drive_n, found);
    next_cycle();
    analog_cmp1 = 1'b0;
    model_fault = 1'b1;
    for (int i = 0; i <= FAULT_STEPS; i++) begin
      if (i > 0) begin
        send_step($urandom % 2, 2);
      end
      @(negedge clk);
      compare_fault(test, 1'b0, faultn);
      compare_phase(test, model_phase, phase_ct);
      compare_gates(test, "gates_b", expect_bridge(1'b1, DECAY_DRIVE, 1'b1), gates_b);
      if (gates_a.p1.high || gates_a.p2.high || gates_b.p1.high || gates_b.p2.high) begin
        report_failure(test, "a high-side gate is on while the fault is latched");
      end
      if (!(bridge_shows(1'b0, DECAY_FAST) || bridge_shows(1'b0, DECAY_SLOW) ||
            bridge_shows(1'b0, DECAY_DRIVE))) begin
        report_failure(test, $sformatf("bridge A gates %b fit no decay mode", gates_a));
      end
    end
  endtask

  task automatic check_inverted(input string test);
    drive_pattern_t p;
    bridge_gates_t  plain_a;
    bridge_gates_t  plain_b;
    p = pattern_of(model_phase[1:0]);
    plain_a = model_bridge(DECAY_DRIVE, p.s1, p.s2, 1'b0, 1'b1, 1'b0, 1'b0);
    plain_b = model_bridge(DECAY_DRIVE, p.s3, p.s4, 1'b0, 1'b1, 1'b0, 1'b0);
    compare_gates(test, "inverted gates_a", bridge_gates_t'(~plain_a), gates_a);
    compare_gates(test, "inverted gates_b", bridge_gates_t'(~plain_b), gates_b);
  endtask

  task automatic test_polarity();
    string test;
    test = "test_polarity";
    next_cycle();
    drive_cfg.invert_highside = 1'b1;
    drive_cfg.invert_lowside = 1'b1;
    chop_cfg = '{blank_time: DECAY_BLANK, off_time: DECAY_OFF, min_on_time: DECAY_MIN_ON};
    apply_reset(test);
    repeat (2) next_cycle();
    @(negedge clk);
    check_inverted(test);
    for (int i = 0; i < POLARITY_STEPS; i++) begin
      send_step(1'b1, 1);
      @(negedge clk);
      compare_phase(test, model_phase, phase_ct);
      check_inverted(test);
    end
  endtask

  initial begin
    void'($urandom(32'h4660_27b6));
    clk = 1'b0;
    resetn = 1'b0;
    step = 1'b0;
    dir = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    chop_cfg = '{blank_time: DECAY_BLANK, off_time: DECAY_OFF, min_on_time: DECAY_MIN_ON};
    drive_cfg = '{fastdecay_threshold: `FASTDECAY_DEFAULT, invert_highside: 1'b0,
                  invert_lowside: 1'b0};
    model_phase = '0;
    model_fault = 1'b0;
    error_count = 0;
    check_count = 0;

    test_reset();
    test_stepping();
    test_decay();
    test_blanking();
    test_fault();
    test_polarity();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
